/* rtl/rv_int_pkg.sv */
package rv_int_pkg;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_load   = 7'b0000011;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // forwards operand b, used by lui
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    load_byte,
    load_half,
    load_word
  } load_size_e;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    // operand a taken from the pc (auipc)
    logic        a_is_pc;
    logic        b_is_imm;
    logic        writes_rd;
    logic        is_load;
    load_size_e  load_size;
    logic        load_signed;
  } decoded_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } mem_req_t;

  // writeback, register file write and bypass source
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

endpackage

/* rtl/instr_decoder.sv */
module instr_decoder (
  input  logic [31:0]          inst,
  output rv_int_pkg::decoded_t dec
);
  import rv_int_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic        is_op;
  logic        plain_f7;
  logic        alt_f7;
  alu_op_e     arith_op;
  logic        arith_ok;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign imm_i    = {{20{inst[31]}}, inst[31:20]};
  assign imm_u    = {inst[31:12], 12'h000};
  assign is_op    = opcode == opc_op;
  assign plain_f7 = funct7 == 7'b0000000;
  assign alt_f7   = funct7 == 7'b0100000;

  // funct3 and funct7 shared by op and op-imm
  // op-imm has no funct7 except on shifts
  always_comb begin
    arith_op = alu_add;
    arith_ok = 1'b1;
    case (funct3)
      3'b000: begin
        arith_op = (is_op && alt_f7) ? alu_sub : alu_add;
        arith_ok = !is_op || plain_f7 || alt_f7;
      end
      3'b001: begin
        arith_op = alu_sll;
        arith_ok = plain_f7;
      end
      3'b010: begin
        arith_op = alu_slt;
        arith_ok = !is_op || plain_f7;
      end
      3'b011: begin
        arith_op = alu_sltu;
        arith_ok = !is_op || plain_f7;
      end
      3'b100: begin
        arith_op = alu_xor;
        arith_ok = !is_op || plain_f7;
      end
      3'b101: begin
        arith_op = alt_f7 ? alu_sra : alu_srl;
        arith_ok = plain_f7 || alt_f7;
      end
      3'b110: begin
        arith_op = alu_or;
        arith_ok = !is_op || plain_f7;
      end
      default: begin
        arith_op = alu_and;
        arith_ok = !is_op || plain_f7;
      end
    endcase
  end

  always_comb begin
    dec           = '0;
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];
    dec.rd        = inst[11:7];
    dec.alu_op    = alu_add;
    dec.load_size = load_word;
    case (opcode)
      opc_lui: begin
        dec.imm       = imm_u;
        dec.alu_op    = alu_pass_b;
        dec.b_is_imm  = 1'b1;
        dec.writes_rd = 1'b1;
      end
      opc_auipc: begin
        dec.imm       = imm_u;
        dec.a_is_pc   = 1'b1;
        dec.b_is_imm  = 1'b1;
        dec.writes_rd = 1'b1;
      end
      opc_op_imm: begin
        dec.imm       = imm_i;
        dec.alu_op    = arith_op;
        dec.use_rs1   = arith_ok;
        dec.b_is_imm  = 1'b1;
        dec.writes_rd = arith_ok;
      end
      opc_op: begin
        dec.alu_op    = arith_op;
        dec.use_rs1   = arith_ok;
        dec.use_rs2   = arith_ok;
        dec.writes_rd = arith_ok;
      end
      opc_load: begin
        dec.imm      = imm_i;
        dec.b_is_imm = 1'b1;
        // lb, lh, lw, lbu, lhu
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          dec.use_rs1     = 1'b1;
          dec.writes_rd   = 1'b1;
          dec.is_load     = 1'b1;
          dec.load_signed = !funct3[2];
          dec.load_size   = (funct3[1:0] == 2'b00) ? load_byte :
                            (funct3[1:0] == 2'b01) ? load_half : load_word;
        end
      end
      default: begin
        // outside the subset, retires with no writeback
        dec.imm = '0;
      end
    endcase
  end

endmodule

/* rtl/register_file.sv */
module register_file (
  input  logic            clock,
  input  logic [4:0]      raddr_a,
  input  logic [4:0]      raddr_b,
  output logic [31:0]     rdata_a,
  output logic [31:0]     rdata_b,
  input  rv_int_pkg::wb_t write
);
  import rv_int_pkg::*;

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (write.valid && write.rd != 5'd0) begin
      regs[write.rd] <= write.data;
    end
  end

  // asynchronous reads, same-cycle write is covered by the wb bypass
  assign rdata_a = (raddr_a == 5'd0) ? 32'h0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? 32'h0 : regs[raddr_b];

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 inst_valid,
  input  logic [31:0]          inst,
  input  logic [31:0]          pc,
  output logic                 inst_ready,
  output logic [4:0]           rf_raddr_a,
  output logic [4:0]           rf_raddr_b,
  input  logic [31:0]          rf_rdata_a,
  input  logic [31:0]          rf_rdata_b,
  input  rv_int_pkg::wb_t      ex_fwd,
  input  rv_int_pkg::wb_t      wb,
  output logic                 ex_valid,
  output rv_int_pkg::decoded_t ex_dec,
  output logic [31:0]          ex_pc,
  output logic [31:0]          operand_a,
  output logic [31:0]          operand_b
);
  import rv_int_pkg::*;

  logic        valid_q;
  logic [31:0] inst_q;
  logic [31:0] pc_q;
  decoded_t    held;
  decoded_t    offer;
  logic        held_load;
  logic        hit_rs1;
  logic        hit_rs2;
  logic        accept;
  logic [31:0] rs2_value;

  // execute result wins over writeback, writeback over the register file
  function automatic logic [31:0] bypass(input logic [4:0] rs, input logic [31:0] rf_data,
                                         input wb_t fwd_ex, input wb_t fwd_wb);
    if (rs == 5'd0) begin
      return 32'h0;
    end else if (fwd_ex.valid && fwd_ex.rd == rs) begin
      return fwd_ex.data;
    end else if (fwd_wb.valid && fwd_wb.rd == rs) begin
      return fwd_wb.data;
    end
    return rf_data;
  endfunction

  instr_decoder i_held_decoder (
    .inst (inst_q),
    .dec  (held)
  );

  // source fields of the offered word for the load-use check
  instr_decoder i_offer_decoder (
    .inst (inst),
    .dec  (offer)
  );

  assign held_load  = valid_q && held.is_load && held.rd != 5'd0;
  assign hit_rs1    = offer.use_rs1 && offer.rs1 == held.rd;
  assign hit_rs2    = offer.use_rs2 && offer.rs2 == held.rd;
  assign inst_ready = !(inst_valid && held_load && (hit_rs1 || hit_rs2));
  assign accept     = inst_valid && inst_ready;

  // a stall or an idle source leaves a bubble
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      inst_q <= inst;
      pc_q   <= pc;
    end
  end

  assign rf_raddr_a = held.rs1;
  assign rf_raddr_b = held.rs2;

  assign rs2_value = bypass(held.rs2, rf_rdata_b, ex_fwd, wb);
  assign operand_a = bypass(held.rs1, rf_rdata_a, ex_fwd, wb);
  assign operand_b = held.b_is_imm ? held.imm : rs2_value;

  assign ex_valid = valid_q;
  assign ex_dec   = held;
  assign ex_pc    = pc_q;

endmodule

/* rtl/execute_stage.sv */
module execute_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ex_valid,
  input  rv_int_pkg::decoded_t ex_dec,
  input  logic [31:0]          ex_pc,
  input  logic [31:0]          operand_a,
  input  logic [31:0]          operand_b,
  output rv_int_pkg::mem_req_t mem_req,
  input  logic [31:0]          mem_rdata,
  output rv_int_pkg::wb_t      ex_fwd,
  output rv_int_pkg::wb_t      wb
);
  import rv_int_pkg::*;

  // contents of the execute and writeback registers
  typedef struct packed {
    logic        write;
    logic        is_load;
    load_size_e  load_size;
    logic        load_signed;
    logic [4:0]  rd;
    logic [31:0] result;
  } stage_t;

  stage_t      ex_next;
  stage_t      ex_q;
  stage_t      wb_q;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [4:0]  shamt;
  logic [31:0] alu_result;
  logic [31:0] lane;
  logic [31:0] load_data;

  // auipc adds the immediate to the pc
  assign alu_a = ex_dec.a_is_pc ? ex_pc : operand_a;
  assign alu_b = operand_b;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (ex_dec.alu_op)
      alu_add:    alu_result = alu_a + alu_b;
      alu_sub:    alu_result = alu_a - alu_b;
      alu_sll:    alu_result = alu_a << shamt;
      alu_slt:    alu_result = {31'h0, $signed(alu_a) < $signed(alu_b)};
      alu_sltu:   alu_result = {31'h0, alu_a < alu_b};
      alu_xor:    alu_result = alu_a ^ alu_b;
      alu_srl:    alu_result = alu_a >> shamt;
      alu_sra:    alu_result = $unsigned($signed(alu_a) >>> shamt);
      alu_or:     alu_result = alu_a | alu_b;
      alu_and:    alu_result = alu_a & alu_b;
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = 32'h0;
    endcase
  end

  always_comb begin
    ex_next.write       = ex_valid && ex_dec.writes_rd && ex_dec.rd != 5'd0;
    ex_next.is_load     = ex_valid && ex_dec.is_load;
    ex_next.load_size   = ex_dec.load_size;
    ex_next.load_signed = ex_dec.load_signed;
    ex_next.rd          = ex_dec.rd;
    ex_next.result      = alu_result;
  end

  always_ff @(posedge clock) begin
    ex_q <= ex_next;
    wb_q <= ex_q;
    if (reset) begin
      ex_q.write   <= 1'b0;
      ex_q.is_load <= 1'b0;
      wb_q.write   <= 1'b0;
      wb_q.is_load <= 1'b0;
    end
  end

  // the load address is the alu result held in the execute register
  assign mem_req.valid = ex_q.is_load;
  assign mem_req.addr  = ex_q.result;

  // load results are not ready yet, so they are never forwarded from here
  assign ex_fwd.valid = ex_q.write && !ex_q.is_load;
  assign ex_fwd.rd    = ex_q.rd;
  assign ex_fwd.data  = ex_q.result;

  // mem_rdata arrives while the load sits in the writeback register
  assign lane = mem_rdata >> {wb_q.result[1:0], 3'b000};

  always_comb begin
    case (wb_q.load_size)
      load_byte: load_data = {{24{wb_q.load_signed && lane[7]}}, lane[7:0]};
      load_half: load_data = {{16{wb_q.load_signed && lane[15]}}, lane[15:0]};
      default:   load_data = mem_rdata;
    endcase
  end

  assign wb.valid = wb_q.write;
  assign wb.rd    = wb_q.rd;
  assign wb.data  = wb_q.is_load ? load_data : wb_q.result;

endmodule

/* rtl/rv_int_pipe.sv */
module rv_int_pipe (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 inst_valid,
  input  logic [31:0]          inst,
  input  logic [31:0]          pc,
  output logic                 inst_ready,
  output rv_int_pkg::mem_req_t mem_req,
  input  logic [31:0]          mem_rdata,
  output rv_int_pkg::wb_t      wb
);
  import rv_int_pkg::*;

  logic [4:0]  rf_raddr_a;
  logic [4:0]  rf_raddr_b;
  logic [31:0] rf_rdata_a;
  logic [31:0] rf_rdata_b;
  wb_t         ex_fwd;
  logic        ex_valid;
  decoded_t    ex_dec;
  logic [31:0] ex_pc;
  logic [31:0] operand_a;
  logic [31:0] operand_b;

  decode_stage i_decode_stage (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .inst_ready (inst_ready),
    .rf_raddr_a (rf_raddr_a),
    .rf_raddr_b (rf_raddr_b),
    .rf_rdata_a (rf_rdata_a),
    .rf_rdata_b (rf_rdata_b),
    .ex_fwd     (ex_fwd),
    .wb         (wb),
    .ex_valid   (ex_valid),
    .ex_dec     (ex_dec),
    .ex_pc      (ex_pc),
    .operand_a  (operand_a),
    .operand_b  (operand_b)
  );

  // written from the writeback port
  register_file i_register_file (
    .clock   (clock),
    .raddr_a (rf_raddr_a),
    .raddr_b (rf_raddr_b),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b),
    .write   (wb)
  );

  execute_stage i_execute_stage (
    .clock     (clock),
    .reset     (reset),
    .ex_valid  (ex_valid),
    .ex_dec    (ex_dec),
    .ex_pc     (ex_pc),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .ex_fwd    (ex_fwd),
    .wb        (wb)
  );

endmodule

/* tb/rv_int_pipe_tb.sv */
module rv_int_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_int_pkg::*;

  localparam int num_instr     = 400;
  localparam int ready_timeout = 8;
  localparam int drain_timeout = 12;

  // instruction classes of the generator
  localparam int k_op      = 0;
  localparam int k_imm     = 1;
  localparam int k_lui     = 2;
  localparam int k_auipc   = 3;
  localparam int k_load    = 4;
  localparam int k_illegal = 5;

  logic        clock;
  logic        reset;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        inst_ready;
  mem_req_t    mem_req;
  logic [31:0] mem_rdata;
  wb_t         wb;

  logic [31:0] lfsr;
  logic [31:0] ref_regs [0:31];
  logic [31:0] next_pc;
  logic [31:0] req_addr;
  wb_t         exp_wb [0:2];
  mem_req_t    exp_mem [0:1];
  wb_t         exp_now;
  mem_req_t    exp_req;
  wb_t         acc_wb;
  mem_req_t    acc_mem;
  int          cur_kind;
  logic [2:0]  cur_f3;
  logic        cur_alt;
  logic [4:0]  cur_rs1;
  logic [4:0]  cur_rs2;
  logic [4:0]  cur_rd;
  logic [31:0] cur_imm;
  logic [31:0] cur_word;
  // source fields of the offered instruction
  logic        off_use1;
  logic        off_use2;
  logic        off_load;
  logic [4:0]  off_rs1;
  logic [4:0]  off_rs2;
  logic [4:0]  off_rd;
  logic [4:0]  held_load_rd;
  logic [4:0]  prev_load_rd;
  logic        exp_ready;
  int          stall_count;
  int          pair_count;

  rv_int_pipe i_rv_int_pipe (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .inst_ready (inst_ready),
    .mem_req    (mem_req),
    .mem_rdata  (mem_rdata),
    .wb         (wb)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_fail(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    abort_run($sformatf("[FAIL] %s expected %h actual %h", name, exp_v, act_v));
  endtask

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // every word address gets its own value
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:2], 2'b00};
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  // address of the request made in the cycle that just ended
  always @(posedge clock) begin
    req_addr <= mem_req.addr;
  end

  // the data port answers in the cycle after the request
  always @(negedge clock) begin
    mem_rdata <= mem_word(req_addr);
  end

  assign exp_now   = exp_wb[2];
  assign exp_req   = exp_mem[1];
  assign exp_ready = !(held_load_rd != 5'd0 &&
                       ((off_use1 && off_rs1 == held_load_rd) ||
                        (off_use2 && off_rs2 == held_load_rd)));

  // expected outputs move along with the pipeline
  always @(posedge clock) begin
    if (reset) begin
      exp_wb[0]    <= '0;
      exp_wb[1]    <= '0;
      exp_wb[2]    <= '0;
      exp_mem[0]   <= '0;
      exp_mem[1]   <= '0;
      held_load_rd <= 5'd0;
    end else begin
      exp_wb[0]    <= (inst_valid && inst_ready) ? acc_wb : '0;
      exp_wb[1]    <= exp_wb[0];
      exp_wb[2]    <= exp_wb[1];
      exp_mem[0]   <= (inst_valid && inst_ready) ? acc_mem : '0;
      exp_mem[1]   <= exp_mem[0];
      held_load_rd <= (inst_valid && inst_ready && off_load) ? off_rd : 5'd0;
    end
  end

  wb_check: assert property (@(posedge clock) disable iff (reset)
    wb.valid == exp_now.valid && (!exp_now.valid || wb == exp_now))
    else value_fail("writeback", $sampled(exp_now), $sampled(wb));

  mem_check: assert property (@(posedge clock) disable iff (reset)
    mem_req.valid == exp_req.valid && (!exp_req.valid || mem_req == exp_req))
    else value_fail("load request", $sampled(exp_req), $sampled(mem_req));

  ready_check: assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> inst_ready == exp_ready)
    else value_fail("load-use ready", $sampled(exp_ready), $sampled(inst_ready));

  reset_check: assert property (@(posedge clock)
    $fell(reset) |-> inst_ready && !wb.valid && !mem_req.valid)
    else abort_run("outputs were not idle right after reset");

  task automatic pick_random();
    logic [2:0] sel;
    sel      = take_bits(3);
    cur_kind = (sel < 2) ? k_op : (sel < 4) ? k_imm : (sel == 4) ? k_lui :
               (sel == 5) ? k_auipc : (sel == 6) ? k_load : k_illegal;
    cur_rd   = take_bits(3);
    cur_rs1  = take_bits(3);
    cur_rs2  = take_bits(3);
    cur_f3   = take_bits(3);
    cur_alt  = take_bits(1);
    cur_imm  = take_bits(12);
    cur_imm  = {{20{cur_imm[11]}}, cur_imm[11:0]};
    if (cur_kind == k_op) begin
      cur_alt = cur_alt && (cur_f3 == 3'd0 || cur_f3 == 3'd5);
    end else if (cur_kind == k_imm) begin
      // shift immediates carry funct7 in the top bits
      if (cur_f3 == 3'd1 || cur_f3 == 3'd5) begin
        cur_alt = cur_alt && cur_f3 == 3'd5;
        cur_imm = {20'h0, cur_alt ? 7'b0100000 : 7'b0000000, cur_imm[4:0]};
      end else begin
        cur_alt = 1'b0;
      end
    end else if (cur_kind == k_lui || cur_kind == k_auipc) begin
      cur_imm = take_bits(20) << 12;
    end else if (cur_kind == k_load) begin
      sel    = take_bits(3) % 5;
      cur_f3 = (sel > 2) ? sel + 3'd1 : sel;
    end
  endtask

  task automatic encode_cur();
    case (cur_kind)
      k_op:    cur_word = {cur_alt ? 7'b0100000 : 7'b0000000, cur_rs2, cur_rs1, cur_f3,
                           cur_rd, opc_op};
      k_imm:   cur_word = {cur_imm[11:0], cur_rs1, cur_f3, cur_rd, opc_op_imm};
      k_lui:   cur_word = {cur_imm[31:12], cur_rd, opc_lui};
      k_auipc: cur_word = {cur_imm[31:12], cur_rd, opc_auipc};
      k_load:  cur_word = {cur_imm[11:0], cur_rs1, cur_f3, cur_rd, opc_load};
      // a store opcode lies outside the subset
      default: cur_word = {cur_imm[24:0], 7'b0100011};
    endcase
  endtask

  // reference model that runs in program order at acceptance
  task automatic retire_ref();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] lane;
    logic        wr;
    a       = ref_regs[cur_rs1];
    b       = (cur_kind == k_op) ? ref_regs[cur_rs2] : cur_imm;
    wr      = 1'b1;
    res     = '0;
    acc_mem = '0;
    case (cur_kind)
      k_op, k_imm: begin
        case (cur_f3)
          3'd0: res = (cur_kind == k_op && cur_alt) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: res = (a < b) ? 32'd1 : 32'd0;
          3'd4: res = a ^ b;
          3'd5: res = cur_alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      k_lui:   res = cur_imm;
      k_auipc: res = pc + cur_imm;
      k_load: begin
        acc_mem.valid = 1'b1;
        acc_mem.addr  = a + cur_imm;
        lane          = mem_word(acc_mem.addr) >> (8 * acc_mem.addr[1:0]);
        case (cur_f3)
          3'd0: res = {{24{lane[7]}}, lane[7:0]};
          3'd1: res = {{16{lane[15]}}, lane[15:0]};
          3'd4: res = {24'h0, lane[7:0]};
          3'd5: res = {16'h0, lane[15:0]};
          default: res = mem_word(acc_mem.addr);
        endcase
      end
      default: wr = 1'b0;
    endcase
    acc_wb.valid = wr && cur_rd != 5'd0;
    acc_wb.rd    = cur_rd;
    acc_wb.data  = res;
    if (acc_wb.valid) begin
      ref_regs[cur_rd] = res;
    end
  endtask

  // offer cur_word at this falling edge and wait until it is taken
  task automatic issue();
    int waited;
    inst_valid = 1'b1;
    inst       = cur_word;
    pc         = next_pc;
    off_use1   = cur_kind == k_op || cur_kind == k_imm || cur_kind == k_load;
    off_use2   = cur_kind == k_op;
    off_load   = cur_kind == k_load;
    off_rs1    = cur_rs1;
    off_rs2    = cur_rs2;
    off_rd     = cur_rd;
    if (prev_load_rd != 5'd0 && ((off_use1 && cur_rs1 == prev_load_rd) ||
                                 (off_use2 && cur_rs2 == prev_load_rd))) begin
      pair_count++;
    end
    waited = 0;
    #1;
    while (!inst_ready) begin
      stall_count++;
      waited++;
      if (waited > ready_timeout) begin
        abort_run("inst_ready stayed low, instruction never accepted");
      end
      @(negedge clock);
      #1;
    end
    retire_ref();
    @(negedge clock);
    inst_valid   = 1'b0;
    next_pc      = next_pc + 32'd4;
    prev_load_rd = off_load ? off_rd : 5'd0;
  endtask

  initial begin
    int n;
    int waited;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    pc           = '0;
    mem_rdata    = '0;
    lfsr         = 32'd54789;
    next_pc      = 32'h0000_1000;
    acc_wb       = '0;
    acc_mem      = '0;
    off_use1     = 1'b0;
    off_use2     = 1'b0;
    off_load     = 1'b0;
    off_rs1      = '0;
    off_rs2      = '0;
    off_rd       = '0;
    prev_load_rd = '0;
    stall_count  = 0;
    pair_count   = 0;
    for (n = 0; n < 32; n++) begin
      ref_regs[n] = '0;
    end
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // give x1..x7 known values with addi
    for (n = 1; n < 8; n++) begin
      cur_kind = k_imm;
      cur_f3   = 3'd0;
      cur_alt  = 1'b0;
      cur_rs1  = 5'd0;
      cur_rs2  = 5'd0;
      cur_rd   = n;
      cur_imm  = take_bits(12);
      cur_imm  = {{20{cur_imm[11]}}, cur_imm[11:0]};
      encode_cur();
      issue();
    end

    for (n = 0; n < num_instr; n++) begin
      pick_random();
      encode_cur();
      if (take_bits(2) == 0) begin
        @(negedge clock);
        prev_load_rd = 5'd0;
      end
      issue();
    end

    waited = 0;
    while (exp_wb[0].valid || exp_wb[1].valid || exp_wb[2].valid ||
           exp_mem[0].valid || exp_mem[1].valid) begin
      waited++;
      if (waited > drain_timeout) begin
        abort_run("pipeline did not drain after the last instruction");
      end
      @(negedge clock);
    end

    if (stall_count != pair_count) begin
      value_fail("stall count", pair_count, stall_count);
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* flist.f */
rtl/rv_int_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_int_pipe.sv
tb/rv_int_pipe_tb.sv

/* Bender.yml */
package:
  name: rv_int_pipe

sources:
  - rtl/rv_int_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/register_file.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/rv_int_pipe.sv
  - target: simulation
    files:
      - tb/rv_int_pipe_tb.sv
